// ==== rtl/soc_pkg.sv ====
package soc_pkg;

    // --------------------
    // Widths and types
    // --------------------
    localparam int WB_WIDTH     = 32;
    localparam int GPIO_COUNT   = 38;
    localparam int GPIO_HI_BITS = GPIO_COUNT - WB_WIDTH;  // Pads held in the HI registers
    localparam int IRQ_COUNT    = 3;

    typedef logic [WB_WIDTH-1:0]   wb_addr_t;
    typedef logic [WB_WIDTH-1:0]   wb_data_t;
    typedef logic [WB_WIDTH/8-1:0] wb_sel_t;
    typedef logic [GPIO_COUNT-1:0] gpio_t;
    typedef logic [IRQ_COUNT-1:0]  irq_t;
    typedef logic [2:0]            reg_offset_t;
    typedef logic [3:0]            win_t;

    // --------------------
    // Address map
    // --------------------
    localparam int   WIN_MSB    = 11;  // Window select field
    localparam int   WIN_LSB    = 8;
    localparam int   OFS_MSB    = 4;   // Word offset field
    localparam int   OFS_LSB    = 2;
    localparam win_t WIN_GLOBAL = 4'd0;
    localparam win_t WIN_GPIO   = 4'd1;
    localparam win_t WIN_IRQ    = 4'd2;

    // Global window
    localparam reg_offset_t GLB_CHIP_ID    = 3'd0;
    localparam reg_offset_t GLB_SOFT_RST   = 3'd1;
    localparam wb_data_t    CHIP_ID        = 32'h5553_0001;
    localparam logic        SOFT_RST_RESET = 1'b1;  // Blocks running

    // GPIO window
    localparam reg_offset_t GPIO_OUT_LO = 3'd0;
    localparam reg_offset_t GPIO_OUT_HI = 3'd1;
    localparam reg_offset_t GPIO_OEB_LO = 3'd2;
    localparam reg_offset_t GPIO_OEB_HI = 3'd3;
    localparam reg_offset_t GPIO_IN_LO  = 3'd4;
    localparam reg_offset_t GPIO_IN_HI  = 3'd5;
    localparam gpio_t       OEB_RESET   = '1;  // All pads inputs

    // Interrupt window
    localparam reg_offset_t IRQ_STATUS   = 3'd0;
    localparam reg_offset_t IRQ_MASK     = 3'd1;
    localparam int          IRQ_PIN_BASE = 8;

    localparam wb_data_t UNMAPPED_DATA = 32'hBAD0_BAD0;

    // --------------------
    // Bus and register request
    // --------------------
    typedef struct packed {
        logic     cyc;
        logic     stb;
        wb_addr_t adr;
        logic     we;
        wb_data_t dat;
        wb_sel_t  sel;
    } wb_req_t;

    typedef struct packed {
        logic        wr;
        reg_offset_t offset;
        wb_data_t    wdata;
        wb_sel_t     be;
    } reg_req_t;

    typedef enum logic [1:0] {
        HOST_IDLE,
        HOST_ACCESS,
        HOST_ACK
    } host_state_t;

    // Byte lanes enabled in be take the new value
    function automatic wb_data_t merge_be(wb_data_t old_val, wb_data_t new_val, wb_sel_t be);
        wb_data_t res;
        res = old_val;
        for (int i = 0; i < WB_WIDTH / 8; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

// ==== rtl/wb_host_ctrl.sv ====
`timescale 1ns/1ps

module wb_host_ctrl (
    input  logic              wb_clk_i,
    input  logic              arst_n_i,
    input  soc_pkg::wb_req_t  wb_req_i,
    output soc_pkg::wb_data_t wbs_dat_o,
    output logic              wbs_ack_o,
    output soc_pkg::reg_req_t reg_req_o,
    output logic              gpio_cs_o,
    output logic              irq_cs_o,
    input  soc_pkg::wb_data_t gpio_rdata_i,
    input  soc_pkg::wb_data_t irq_rdata_i,
    output logic              soft_rst_n_o
);

    soc_pkg::host_state_t state_q;
    soc_pkg::win_t        win_d;
    soc_pkg::win_t        win_q;      // Window of the transfer in flight
    soc_pkg::reg_req_t    req_d;
    soc_pkg::wb_data_t    glb_rword;
    logic                 req_valid;
    logic                 req_take;
    logic                 glb_wr;

    assign req_valid = wb_req_i.cyc & wb_req_i.stb;
    assign req_take  = req_valid && (state_q == soc_pkg::HOST_IDLE);
    assign win_d     = wb_req_i.adr[soc_pkg::WIN_MSB:soc_pkg::WIN_LSB];

    assign req_d = '{
        wr:     wb_req_i.we,
        offset: wb_req_i.adr[soc_pkg::OFS_MSB:soc_pkg::OFS_LSB],
        wdata:  wb_req_i.dat,
        be:     wb_req_i.sel
    };

    // --------------------
    // Transfer FSM
    // --------------------
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= soc_pkg::HOST_IDLE;
            gpio_cs_o <= 1'b0;
            irq_cs_o  <= 1'b0;
        end else begin
            gpio_cs_o <= 1'b0;  // Strobes last one cycle
            irq_cs_o  <= 1'b0;
            case (state_q)
                soc_pkg::HOST_IDLE: begin
                    if (req_valid) begin
                        state_q   <= soc_pkg::HOST_ACCESS;
                        gpio_cs_o <= (win_d == soc_pkg::WIN_GPIO);
                        irq_cs_o  <= (win_d == soc_pkg::WIN_IRQ);
                    end
                end
                soc_pkg::HOST_ACCESS: state_q <= soc_pkg::HOST_ACK;
                soc_pkg::HOST_ACK:    state_q <= soc_pkg::HOST_IDLE;
                default:              state_q <= soc_pkg::HOST_IDLE;
            endcase
        end
    end

    assign wbs_ack_o = (state_q == soc_pkg::HOST_ACK);

    // Request held for the whole transfer
    always_ff @(posedge wb_clk_i) begin
        if (req_take) begin
            reg_req_o <= req_d;
            win_q     <= win_d;
        end
    end

    // --------------------
    // Global registers
    // --------------------
    assign glb_wr = (state_q == soc_pkg::HOST_ACCESS) && (win_q == soc_pkg::WIN_GLOBAL)
                  && reg_req_o.wr && (reg_req_o.offset == soc_pkg::GLB_SOFT_RST)
                  && reg_req_o.be[0];

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            soft_rst_n_o <= soc_pkg::SOFT_RST_RESET;
        end else if (glb_wr) begin
            soft_rst_n_o <= reg_req_o.wdata[0];
        end
    end

    always_comb begin
        case (reg_req_o.offset)
            soc_pkg::GLB_CHIP_ID:  glb_rword = soc_pkg::CHIP_ID;
            soc_pkg::GLB_SOFT_RST: glb_rword = soc_pkg::wb_data_t'(soft_rst_n_o);
            default:               glb_rword = soc_pkg::UNMAPPED_DATA;
        endcase
    end

    // Read word for the ack cycle
    always_comb begin
        case (win_q)
            soc_pkg::WIN_GLOBAL: wbs_dat_o = glb_rword;
            soc_pkg::WIN_GPIO:   wbs_dat_o = gpio_rdata_i;
            soc_pkg::WIN_IRQ:    wbs_dat_o = irq_rdata_i;
            default:             wbs_dat_o = soc_pkg::UNMAPPED_DATA;
        endcase
    end

endmodule

// ==== rtl/gpio_regs.sv ====
`timescale 1ns/1ps

module gpio_regs (
    input  logic              wb_clk_i,
    input  logic              arst_n_i,
    input  logic              soft_rst_n_i,
    input  logic              cs_i,
    input  soc_pkg::reg_req_t reg_req_i,
    output soc_pkg::wb_data_t rdata_o,
    input  soc_pkg::gpio_t    io_in_i,
    output soc_pkg::gpio_t    io_out_o,
    output soc_pkg::gpio_t    io_oeb_o,
    output soc_pkg::gpio_t    io_sync_o
);

    localparam int LO_MSB = soc_pkg::WB_WIDTH - 1;
    localparam int HI_MSB = soc_pkg::GPIO_COUNT - 1;

    soc_pkg::gpio_t    out_q;
    soc_pkg::gpio_t    oeb_q;
    soc_pkg::gpio_t    sync1_q;
    soc_pkg::gpio_t    sync2_q;
    soc_pkg::wb_data_t out_lo_w, out_hi_w;  // Register values after a write
    soc_pkg::wb_data_t oeb_lo_w, oeb_hi_w;
    soc_pkg::wb_data_t rword;
    logic              wr_en;

    assign wr_en = cs_i & reg_req_i.wr;

    always_comb begin
        out_lo_w = soc_pkg::merge_be(out_q[LO_MSB:0], reg_req_i.wdata, reg_req_i.be);
        out_hi_w = soc_pkg::merge_be(soc_pkg::wb_data_t'(out_q[HI_MSB:soc_pkg::WB_WIDTH]),
                                     reg_req_i.wdata, reg_req_i.be);
        oeb_lo_w = soc_pkg::merge_be(oeb_q[LO_MSB:0], reg_req_i.wdata, reg_req_i.be);
        oeb_hi_w = soc_pkg::merge_be(soc_pkg::wb_data_t'(oeb_q[HI_MSB:soc_pkg::WB_WIDTH]),
                                     reg_req_i.wdata, reg_req_i.be);
    end

    // --------------------
    // Output and enable registers
    // --------------------
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q <= '0;
            oeb_q <= soc_pkg::OEB_RESET;
        end else if (!soft_rst_n_i) begin
            out_q <= '0;
            oeb_q <= soc_pkg::OEB_RESET;
        end else if (wr_en) begin
            case (reg_req_i.offset)
                soc_pkg::GPIO_OUT_LO: out_q[LO_MSB:0] <= out_lo_w;
                soc_pkg::GPIO_OUT_HI: out_q[HI_MSB:soc_pkg::WB_WIDTH] <=
                                          out_hi_w[soc_pkg::GPIO_HI_BITS-1:0];
                soc_pkg::GPIO_OEB_LO: oeb_q[LO_MSB:0] <= oeb_lo_w;
                soc_pkg::GPIO_OEB_HI: oeb_q[HI_MSB:soc_pkg::WB_WIDTH] <=
                                          oeb_hi_w[soc_pkg::GPIO_HI_BITS-1:0];
                default: ;  // Input offsets are read only
            endcase
        end
    end

    // Two flop pad synchronizer
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            sync1_q <= io_in_i;
            sync2_q <= sync1_q;
        end
    end

    // --------------------
    // Read path
    // --------------------
    always_comb begin
        case (reg_req_i.offset)
            soc_pkg::GPIO_OUT_LO: rword = out_q[LO_MSB:0];
            soc_pkg::GPIO_OUT_HI: rword = soc_pkg::wb_data_t'(out_q[HI_MSB:soc_pkg::WB_WIDTH]);
            soc_pkg::GPIO_OEB_LO: rword = oeb_q[LO_MSB:0];
            soc_pkg::GPIO_OEB_HI: rword = soc_pkg::wb_data_t'(oeb_q[HI_MSB:soc_pkg::WB_WIDTH]);
            soc_pkg::GPIO_IN_LO:  rword = sync2_q[LO_MSB:0];
            soc_pkg::GPIO_IN_HI:  rword = soc_pkg::wb_data_t'(sync2_q[HI_MSB:soc_pkg::WB_WIDTH]);
            default:              rword = soc_pkg::UNMAPPED_DATA;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (cs_i) begin
            rdata_o <= rword;  // Host picks it up in the ack cycle
        end
    end

    assign io_out_o  = out_q;
    assign io_oeb_o  = oeb_q;
    assign io_sync_o = sync2_q;

endmodule

// ==== rtl/irq_ctrl.sv ====
`timescale 1ns/1ps

module irq_ctrl (
    input  logic              wb_clk_i,
    input  logic              arst_n_i,
    input  logic              soft_rst_n_i,
    input  logic              cs_i,
    input  soc_pkg::reg_req_t reg_req_i,
    output soc_pkg::wb_data_t rdata_o,
    input  soc_pkg::gpio_t    io_sync_i,
    output soc_pkg::irq_t     user_irq_o
);

    soc_pkg::irq_t     pins;
    soc_pkg::irq_t     prev_q;
    soc_pkg::irq_t     rise;
    soc_pkg::irq_t     clr;
    soc_pkg::irq_t     status_q;
    soc_pkg::irq_t     mask_q;
    soc_pkg::wb_data_t mask_w;
    soc_pkg::wb_data_t rword;
    logic              wr_en;

    assign pins  = io_sync_i[soc_pkg::IRQ_PIN_BASE +: soc_pkg::IRQ_COUNT];
    assign rise  = pins & ~prev_q;
    assign wr_en = cs_i & reg_req_i.wr;

    // Only the low byte carries status bits to clear
    assign clr = (wr_en && (reg_req_i.offset == soc_pkg::IRQ_STATUS) && reg_req_i.be[0])
               ? reg_req_i.wdata[soc_pkg::IRQ_COUNT-1:0] : '0;

    assign mask_w = soc_pkg::merge_be(soc_pkg::wb_data_t'(mask_q), reg_req_i.wdata, reg_req_i.be);

    // Edge history keeps tracking during soft reset
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prev_q <= '0;
        end else begin
            prev_q <= pins;
        end
    end

    // --------------------
    // Status and mask
    // --------------------
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            status_q <= '0;
            mask_q   <= '0;
        end else if (!soft_rst_n_i) begin
            status_q <= '0;
            mask_q   <= '0;
        end else begin
            status_q <= (status_q & ~clr) | rise;  // New edge beats the clear
            if (wr_en && (reg_req_i.offset == soc_pkg::IRQ_MASK)) begin
                mask_q <= mask_w[soc_pkg::IRQ_COUNT-1:0];
            end
        end
    end

    always_comb begin
        case (reg_req_i.offset)
            soc_pkg::IRQ_STATUS: rword = soc_pkg::wb_data_t'(status_q);
            soc_pkg::IRQ_MASK:   rword = soc_pkg::wb_data_t'(mask_q);
            default:             rword = soc_pkg::UNMAPPED_DATA;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (cs_i) begin
            rdata_o <= rword;
        end
    end

    assign user_irq_o = status_q & mask_q;

endmodule

// ==== rtl/user_soc_top.sv ====
`timescale 1ns/1ps

module user_soc_top (
    input  logic              wb_clk_i,
    input  logic              arst_n_i,
    input  logic              wbs_cyc_i,
    input  logic              wbs_stb_i,
    input  logic              wbs_we_i,
    input  soc_pkg::wb_addr_t wbs_adr_i,
    input  soc_pkg::wb_data_t wbs_dat_i,
    input  soc_pkg::wb_sel_t  wbs_sel_i,
    output soc_pkg::wb_data_t wbs_dat_o,
    output logic              wbs_ack_o,
    input  soc_pkg::gpio_t    io_in_i,
    output soc_pkg::gpio_t    io_out_o,
    output soc_pkg::gpio_t    io_oeb_o,
    output soc_pkg::irq_t     user_irq_o
);

    soc_pkg::wb_req_t  wb_req;
    soc_pkg::reg_req_t reg_req;     // Shared by both register blocks
    soc_pkg::wb_data_t gpio_rdata;
    soc_pkg::wb_data_t irq_rdata;
    soc_pkg::gpio_t    io_sync;
    logic              gpio_cs;
    logic              irq_cs;
    logic              soft_rst_n;

    assign wb_req = '{
        cyc: wbs_cyc_i,
        stb: wbs_stb_i,
        adr: wbs_adr_i,
        we:  wbs_we_i,
        dat: wbs_dat_i,
        sel: wbs_sel_i
    };

    // --------------------
    // Wishbone host
    // --------------------
    wb_host_ctrl u_host (
        .wb_clk_i     (wb_clk_i),
        .arst_n_i     (arst_n_i),
        .wb_req_i     (wb_req),
        .wbs_dat_o    (wbs_dat_o),
        .wbs_ack_o    (wbs_ack_o),
        .reg_req_o    (reg_req),
        .gpio_cs_o    (gpio_cs),
        .irq_cs_o     (irq_cs),
        .gpio_rdata_i (gpio_rdata),
        .irq_rdata_i  (irq_rdata),
        .soft_rst_n_o (soft_rst_n)
    );

    // --------------------
    // Register blocks
    // --------------------
    gpio_regs u_gpio (
        .wb_clk_i     (wb_clk_i),
        .arst_n_i     (arst_n_i),
        .soft_rst_n_i (soft_rst_n),
        .cs_i         (gpio_cs),
        .reg_req_i    (reg_req),
        .rdata_o      (gpio_rdata),
        .io_in_i      (io_in_i),
        .io_out_o     (io_out_o),
        .io_oeb_o     (io_oeb_o),
        .io_sync_o    (io_sync)     // Synchronized pads for edge detection
    );

    irq_ctrl u_irq (
        .wb_clk_i     (wb_clk_i),
        .arst_n_i     (arst_n_i),
        .soft_rst_n_i (soft_rst_n),
        .cs_i         (irq_cs),
        .reg_req_i    (reg_req),
        .rdata_o      (irq_rdata),
        .io_sync_i    (io_sync),
        .user_irq_o   (user_irq_o)
    );

endmodule

// ==== verification/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------
// Counters
// --------------------
int check_count = 0;
int error_count = 0;
int test_errors = 0;  // Errors in the test now running
int test_count  = 0;

task automatic check_data(input string name, input soc_pkg::wb_data_t got,
                          input soc_pkg::wb_data_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        test_errors++;
        $display("ERROR time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    end
endtask

task automatic check_gpio(input string name, input soc_pkg::gpio_t got,
                          input soc_pkg::gpio_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        test_errors++;
        $display("ERROR time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    end
endtask

task automatic check_irq(input string name, input soc_pkg::irq_t got,
                         input soc_pkg::irq_t exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        test_errors++;
        $display("ERROR time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
    end
endtask

// Failures without a value to compare
task automatic note_failure(input string what);
    error_count++;
    test_errors++;
    $display("%0t: %s", $time, what);
endtask

`endif

// ==== verification/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

    localparam int    ACK_TIMEOUT  = 50;   // Cycles allowed per bus transfer
    localparam int    POLL_TIMEOUT = 200;
    localparam int    POLL_TRIES   = 20;   // Reads of a pad input before giving up
    localparam int    RAND_ROUNDS  = 16;
    localparam int    RAND_TEST    = 7;
    localparam string GOLDEN_FILE  = "verification/golden_vectors.txt";
    localparam soc_pkg::wb_addr_t OUT_LO_ADDR =
        {20'h0, soc_pkg::WIN_GPIO, 3'b000, soc_pkg::GPIO_OUT_LO, 2'b00};

    logic              wb_clk;
    logic              arst_n;
    logic              wbs_cyc;
    logic              wbs_stb;
    logic              wbs_we;
    soc_pkg::wb_addr_t wbs_adr;
    soc_pkg::wb_data_t wbs_dat_w;
    soc_pkg::wb_sel_t  wbs_sel;
    soc_pkg::wb_data_t wbs_dat_r;
    logic              wbs_ack;
    soc_pkg::gpio_t    io_in;
    soc_pkg::gpio_t    io_out;
    soc_pkg::gpio_t    io_oeb;
    soc_pkg::irq_t     user_irq;

    `include "tb_checks.svh"

    user_soc_top UUT (
        .wb_clk_i   (wb_clk),
        .arst_n_i   (arst_n),
        .wbs_cyc_i  (wbs_cyc),
        .wbs_stb_i  (wbs_stb),
        .wbs_we_i   (wbs_we),
        .wbs_adr_i  (wbs_adr),
        .wbs_dat_i  (wbs_dat_w),
        .wbs_sel_i  (wbs_sel),
        .wbs_dat_o  (wbs_dat_r),
        .wbs_ack_o  (wbs_ack),
        .io_in_i    (io_in),
        .io_out_o   (io_out),
        .io_oeb_o   (io_oeb),
        .user_irq_o (user_irq)
    );

    initial begin
        wb_clk = 1'b0;
        forever begin
            #4 wb_clk = ~wb_clk;  // 8 ns period
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // GPIO_IN offsets sit behind the pad synchronizer
    function automatic logic is_pad_input(input soc_pkg::wb_addr_t adr);
        soc_pkg::win_t        win;
        soc_pkg::reg_offset_t ofs;
        win = adr[soc_pkg::WIN_MSB:soc_pkg::WIN_LSB];
        ofs = adr[soc_pkg::OFS_MSB:soc_pkg::OFS_LSB];
        return (win == soc_pkg::WIN_GPIO) &&
               (ofs == soc_pkg::GPIO_IN_LO || ofs == soc_pkg::GPIO_IN_HI);
    endfunction

    // --------------------
    // Bus tasks
    // --------------------
    task automatic bus_transfer(input logic we, input soc_pkg::wb_addr_t adr,
                                input soc_pkg::wb_data_t dat, input soc_pkg::wb_sel_t sel,
                                output soc_pkg::wb_data_t rdata, output logic ok);
        int waited;
        waited = 0;
        ok     = 1'b0;
        rdata  = 'x;
        @(posedge wb_clk);
        wbs_cyc   <= 1'b1;
        wbs_stb   <= 1'b1;
        wbs_we    <= we;
        wbs_adr   <= adr;
        wbs_dat_w <= dat;
        wbs_sel   <= sel;
        while (!ok && waited < ACK_TIMEOUT) begin
            @(negedge wb_clk);  // ack and data are stable here
            if (wbs_ack === 1'b1) begin
                ok    = 1'b1;
                rdata = wbs_dat_r;
            end
            waited++;
        end
        @(posedge wb_clk);
        wbs_cyc <= 1'b0;  // Dropped on the edge that samples ack
        wbs_stb <= 1'b0;
        wbs_we  <= 1'b0;
        if (!ok) begin
            note_failure($sformatf("No ack within %0d cycles for address %h",
                                   ACK_TIMEOUT, adr));
        end
    endtask

    task automatic read_expect(input soc_pkg::wb_addr_t adr, input soc_pkg::wb_data_t exp);
        soc_pkg::wb_data_t rdata;
        logic              ok;
        int                tries;
        tries = 0;
        bus_transfer(1'b0, adr, '0, 4'hf, rdata, ok);
        while (is_pad_input(adr) && ok && rdata !== exp && tries < POLL_TRIES) begin
            bus_transfer(1'b0, adr, '0, 4'hf, rdata, ok);
            tries++;
        end
        if (ok && is_pad_input(adr) && rdata !== exp) begin
            $display("Pad input at address %h did not settle after %0d reads", adr, POLL_TRIES);
        end
        if (ok) begin
            check_data("wbs_dat_o", rdata, exp);
        end
    endtask

    task automatic wait_irq(input soc_pkg::irq_t exp);
        int waited;
        waited = 0;
        @(negedge wb_clk);
        while (user_irq !== exp && waited < POLL_TIMEOUT) begin
            @(negedge wb_clk);
            waited++;
        end
        if (user_irq !== exp) begin
            $display("Timed out after %0d cycles waiting for user_irq to reach %h",
                     POLL_TIMEOUT, exp);
        end
        check_irq("user_irq_o", user_irq, exp);
    endtask

    task automatic finish_test(input int test);
        if (test_errors == 0) begin
            $display("Test %0d done: ok", test);
        end else begin
            $display("Test %0d done: %0d errors", test, test_errors);
        end
        test_errors = 0;
        test_count++;
    endtask

    // --------------------
    // Golden file
    // --------------------
    task automatic run_golden();
        int                fd;
        int                c;
        int                code;
        int                test;
        logic [7:0]        ch;
        logic [63:0]       f1, f2, f3;
        soc_pkg::wb_data_t rdata;
        logic              ok;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            note_failure($sformatf("Could not open %s", GOLDEN_FILE));
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                ch = c[7:0];
                if (ch == "#") begin
                    while (c != -1 && c[7:0] != "\n") begin
                        c = $fgetc(fd);
                    end
                end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
                    case (ch)
                        "W": begin
                            code = $fscanf(fd, "%d %h %h %h", test, f1, f2, f3);
                            if (code != 4) note_failure("Malformed W line in golden file");
                            else bus_transfer(1'b1, f1[31:0], f2[31:0], f3[3:0], rdata, ok);
                        end
                        "R": begin
                            code = $fscanf(fd, "%d %h %h", test, f1, f2);
                            if (code != 3) note_failure("Malformed R line in golden file");
                            else read_expect(f1[31:0], f2[31:0]);
                        end
                        "P": begin
                            code = $fscanf(fd, "%d %h", test, f1);
                            if (code != 2) begin
                                note_failure("Malformed P line in golden file");
                            end else begin
                                @(posedge wb_clk);
                                io_in <= f1[soc_pkg::GPIO_COUNT-1:0];
                            end
                        end
                        "O": begin
                            code = $fscanf(fd, "%d %h %h", test, f1, f2);
                            if (code != 3) begin
                                note_failure("Malformed O line in golden file");
                            end else begin
                                @(negedge wb_clk);
                                check_gpio("io_out_o", io_out, f1[soc_pkg::GPIO_COUNT-1:0]);
                                check_gpio("io_oeb_o", io_oeb, f2[soc_pkg::GPIO_COUNT-1:0]);
                            end
                        end
                        "Q": begin
                            code = $fscanf(fd, "%d %h", test, f1);
                            if (code != 2) note_failure("Malformed Q line in golden file");
                            else wait_irq(f1[soc_pkg::IRQ_COUNT-1:0]);
                        end
                        "T": begin
                            code = $fscanf(fd, "%d", test);
                            if (code != 1) note_failure("Malformed T line in golden file");
                            else finish_test(test);
                        end
                        default: note_failure($sformatf("Unknown golden operation %c", ch));
                    endcase
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    // Random OUT_LO values written and read back
    task automatic run_random(input int test);
        logic [31:0]       seed;
        soc_pkg::wb_data_t rdata;
        logic              ok;
        seed = 32'h269c2e23;
        for (int i = 0; i < RAND_ROUNDS; i++) begin
            seed = xorshift32(seed);
            bus_transfer(1'b1, OUT_LO_ADDR, seed, 4'hf, rdata, ok);
            bus_transfer(1'b0, OUT_LO_ADDR, '0, 4'hf, rdata, ok);
            if (ok) begin
                check_data("wbs_dat_o", rdata, seed);
            end
            check_data("io_out_o[31:0]", io_out[31:0], seed);
        end
        finish_test(test);
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        arst_n    <= 1'b0;
        wbs_cyc   <= 1'b0;
        wbs_stb   <= 1'b0;
        wbs_we    <= 1'b0;
        wbs_adr   <= '0;
        wbs_dat_w <= '0;
        wbs_sel   <= '0;
        io_in     <= '0;
        repeat (16) @(posedge wb_clk);
        arst_n <= 1'b1;
        @(posedge wb_clk);
        run_golden();
        run_random(RAND_TEST);
        $display("Tests run: %0d, checks: %0d, errors: %0d", test_count, check_count,
                 error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verification/golden_vectors.txt ====
# Columns: op test fields, numbers in hex except the test number (decimal)
# W adr data sel | R adr expected | P io_in | O io_out io_oeb | Q user_irq | T
# Reset values
R 1 000 55530001
R 1 004 00000001
O 1 0000000000 3fffffffff
Q 1 0
R 1 108 ffffffff
R 1 10c 0000003f
R 1 110 00000000
R 1 200 00000000
R 1 204 00000000
T 1
# GPIO writes with byte enables
W 2 100 a1b2c3d4 f
W 2 100 11223344 5
R 2 100 a122c344
W 2 104 ffffffff 1
R 2 104 0000003f
W 2 104 00000015 f
R 2 104 00000015
W 2 108 00000000 3
R 2 108 ffff0000
W 2 10c 00000000 f
W 2 10c 0000ffff 2
R 2 10c 00000000
O 2 15a122c344 00ffff0000
T 2
# Pad inputs
P 3 2ac0def8a5
R 3 110 c0def8a5
R 3 114 0000002a
P 3 3ffffff8ff
R 3 110 fffff8ff
R 3 114 0000003f
W 3 110 00000000 f
R 3 110 fffff8ff
P 3 0000000000
R 3 110 00000000
R 3 200 00000000
T 3
# Interrupt edges, mask and clear
W 4 204 00000005 f
R 4 204 00000005
P 4 0000000700
Q 4 5
R 4 200 00000007
W 4 200 00000001 1
Q 4 4
R 4 200 00000006
W 4 200 00000006 f
Q 4 0
R 4 200 00000000
P 4 0000000000
W 4 204 00000007 1
P 4 0000000200
Q 4 2
R 4 200 00000002
W 4 204 00000000 f
Q 4 0
R 4 200 00000002
T 4
# Soft reset
W 5 204 00000003 f
Q 5 2
W 5 004 00000000 f
R 5 004 00000000
O 5 0000000000 3fffffffff
Q 5 0
R 5 100 00000000
R 5 10c 0000003f
R 5 200 00000000
R 5 204 00000000
W 5 100 12345678 f
R 5 100 00000000
W 5 004 00000001 f
R 5 004 00000001
W 5 100 12345678 f
R 5 100 12345678
O 5 0012345678 3fffffffff
W 5 204 00000007 f
P 5 0000000100
Q 5 1
R 5 200 00000001
R 5 000 55530001
T 5
# Unused windows and offsets
R 6 300 bad0bad0
R 6 f00 bad0bad0
R 6 008 bad0bad0
R 6 118 bad0bad0
R 6 11c bad0bad0
R 6 208 bad0bad0
W 6 300 ffffffff f
W 6 304 00000000 f
W 6 118 ffffffff f
W 6 208 ffffffff f
W 6 008 00000000 f
W 6 000 00000000 f
R 6 000 55530001
R 6 004 00000001
R 6 100 12345678
R 6 200 00000001
R 6 204 00000007
O 6 0012345678 3fffffffff
T 6

// ==== src.f ====
+incdir+verification
rtl/soc_pkg.sv
rtl/wb_host_ctrl.sv
rtl/gpio_regs.sv
rtl/irq_ctrl.sv
rtl/user_soc_top.sv
verification/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_top
FILELIST  := src.f
BUILD_DIR := obj_dir
VFLAGS    := --binary -j 0 --top-module $(TOP) --Mdir $(BUILD_DIR)
LOG       := sim.log
PASS_MSG  := Simulation passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verification/*.svh)
GOLDEN  := verification/golden_vectors.txt

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN) $(GOLDEN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
